// ==== src/axil_pkg.sv ====
package axil_pkg;

  // ------------------------------------------------------------
  // Slice sizing and response codes
  // ------------------------------------------------------------

  // Entries per channel FIFO in the register slice
  localparam int SLICE_DEPTH = 2;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // ------------------------------------------------------------
  // AXI-Lite channel payloads
  // ------------------------------------------------------------

  typedef struct packed {
    logic [31:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [31:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axil_r_t;

endpackage

// ==== src/cfg_pkg.sv ====
package cfg_pkg;

  // ------------------------------------------------------------
  // Slot map
  // ------------------------------------------------------------

  // Decoded slots, the last one has no block behind it
  localparam int NUM_TST = 4;

  // Slot index sits in address bits [15:8], 256B per slot
  localparam int SLOT_LSB = 8;
  localparam int SLOT_W   = 8;

  // Read data for slots without a block
  localparam logic [31:0] UNMAPPED_DATA = 32'hdead_beef;

  // ------------------------------------------------------------
  // Configuration bus
  // ------------------------------------------------------------

  // wr/rd are single-cycle pulses, the rest is held until the next request
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wr;
    logic        rd;
  } cfg_req_t;

  // ack is a single-cycle pulse, rdata valid with it
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } cfg_rsp_t;

endpackage

// ==== src/chan_flop_fifo.sv ====
module chan_flop_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     sync_rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t                                       mem [axil_pkg::SLICE_DEPTH];
  logic [$clog2(axil_pkg::SLICE_DEPTH)-1:0]       wr_ptr;
  logic [$clog2(axil_pkg::SLICE_DEPTH)-1:0]       rd_ptr;
  logic [$clog2(axil_pkg::SLICE_DEPTH + 1)-1:0]   count;
  logic                                           push;
  logic                                           pop;

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign in_ready  = (count != axil_pkg::SLICE_DEPTH);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  // Entry storage
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == axil_pkg::SLICE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == axil_pkg::SLICE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // Stalled head entry must not move
  a_hold_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    out_valid && !out_ready |=> $stable(out_data));

endmodule

// ==== src/axil_reg_slice.sv ====
module axil_reg_slice (
  input  logic               clk,
  input  logic               sync_rst_n,
  // Host side
  input  axil_pkg::axil_aw_t s_aw,
  input  logic               s_aw_valid,
  output logic               s_aw_ready,
  input  axil_pkg::axil_w_t  s_w,
  input  logic               s_w_valid,
  output logic               s_w_ready,
  output axil_pkg::axil_b_t  s_b,
  output logic               s_b_valid,
  input  logic               s_b_ready,
  input  axil_pkg::axil_ar_t s_ar,
  input  logic               s_ar_valid,
  output logic               s_ar_ready,
  output axil_pkg::axil_r_t  s_r,
  output logic               s_r_valid,
  input  logic               s_r_ready,
  // Slave side
  output axil_pkg::axil_aw_t m_aw,
  output logic               m_aw_valid,
  input  logic               m_aw_ready,
  output axil_pkg::axil_w_t  m_w,
  output logic               m_w_valid,
  input  logic               m_w_ready,
  input  axil_pkg::axil_b_t  m_b,
  input  logic               m_b_valid,
  output logic               m_b_ready,
  output axil_pkg::axil_ar_t m_ar,
  output logic               m_ar_valid,
  input  logic               m_ar_ready,
  input  axil_pkg::axil_r_t  m_r,
  input  logic               m_r_valid,
  output logic               m_r_ready
);

  // Request channels, host to slave
  chan_flop_fifo #(.payload_t(axil_pkg::axil_aw_t)) u_aw_fifo (
    .clk, .sync_rst_n,
    .in_data(s_aw), .in_valid(s_aw_valid), .in_ready(s_aw_ready),
    .out_data(m_aw), .out_valid(m_aw_valid), .out_ready(m_aw_ready)
  );

  chan_flop_fifo #(.payload_t(axil_pkg::axil_w_t)) u_w_fifo (
    .clk, .sync_rst_n,
    .in_data(s_w), .in_valid(s_w_valid), .in_ready(s_w_ready),
    .out_data(m_w), .out_valid(m_w_valid), .out_ready(m_w_ready)
  );

  chan_flop_fifo #(.payload_t(axil_pkg::axil_ar_t)) u_ar_fifo (
    .clk, .sync_rst_n,
    .in_data(s_ar), .in_valid(s_ar_valid), .in_ready(s_ar_ready),
    .out_data(m_ar), .out_valid(m_ar_valid), .out_ready(m_ar_ready)
  );

  // Response channels, slave back to host
  chan_flop_fifo #(.payload_t(axil_pkg::axil_b_t)) u_b_fifo (
    .clk, .sync_rst_n,
    .in_data(m_b), .in_valid(m_b_valid), .in_ready(m_b_ready),
    .out_data(s_b), .out_valid(s_b_valid), .out_ready(s_b_ready)
  );

  chan_flop_fifo #(.payload_t(axil_pkg::axil_r_t)) u_r_fifo (
    .clk, .sync_rst_n,
    .in_data(m_r), .in_valid(m_r_valid), .in_ready(m_r_ready),
    .out_data(s_r), .out_valid(s_r_valid), .out_ready(s_r_ready)
  );

endmodule

// ==== src/ocl_slv.sv ====
module ocl_slv (
  input  logic               clk,
  input  logic               sync_rst_n,
  input  axil_pkg::axil_aw_t aw,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  axil_pkg::axil_w_t  w,
  input  logic               w_valid,
  output logic               w_ready,
  input  axil_pkg::axil_ar_t ar,
  input  logic               ar_valid,
  output logic               ar_ready,
  output axil_pkg::axil_b_t  b,
  output logic               b_valid,
  input  logic               b_ready,
  output axil_pkg::axil_r_t  r,
  output logic               r_valid,
  input  logic               r_ready,
  output cfg_pkg::cfg_req_t  cfg_req [cfg_pkg::NUM_TST],
  input  cfg_pkg::cfg_rsp_t  cfg_rsp [cfg_pkg::NUM_TST]
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WR_ADDR,
    ST_CYC,
    ST_RESP
  } slv_state_t;

  slv_state_t                   state;
  slv_state_t                   state_nxt;
  logic                         cyc_wr;
  logic [31:0]                  req_addr;
  logic [cfg_pkg::SLOT_W-1:0]   slot_sel;
  logic                         req_valid;
  logic                         rsp_ready;
  logic                         req_fire;
  logic                         did_req;
  logic                         sel_ack;
  logic [31:0]                  sel_rdata;
  logic                         cyc_done;
  logic [31:0]                  rdata_q;
  logic [31:0]                  slot_addr  [cfg_pkg::NUM_TST];
  logic [31:0]                  slot_wdata [cfg_pkg::NUM_TST];
  logic [3:0]                   slot_wstrb [cfg_pkg::NUM_TST];
  logic [cfg_pkg::NUM_TST-1:0]  slot_wr;
  logic [cfg_pkg::NUM_TST-1:0]  slot_rd;

  // Write data must be present before a write cycle goes out
  assign req_valid = cyc_wr ? w_valid : 1'b1;
  assign rsp_ready = cyc_wr ? b_ready : r_ready;
  assign slot_sel  = req_addr[cfg_pkg::SLOT_LSB +: cfg_pkg::SLOT_W];
  assign req_fire  = (state == ST_CYC) && req_valid && !did_req;

  // ------------------------------------------------------------
  // Arbitration and state machine
  // ------------------------------------------------------------

  // Writes win over reads
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      cyc_wr <= 1'b0;
    else if (state == ST_IDLE)
      cyc_wr <= aw_valid;
  end

  always_ff @(posedge clk)
  begin
    if ((state == ST_IDLE) && (aw_valid || ar_valid))
      req_addr <= aw_valid ? aw.addr : ar.addr;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (aw_valid)
          state_nxt = ST_WR_ADDR;
        else if (ar_valid)
          state_nxt = ST_CYC;
      end
      ST_WR_ADDR:
        state_nxt = ST_CYC;
      ST_CYC:
      begin
        if (cyc_done)
          state_nxt = ST_RESP;
      end
      ST_RESP:
      begin
        if (rsp_ready)
          state_nxt = ST_IDLE;
      end
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // ------------------------------------------------------------
  // Slot cycles
  // ------------------------------------------------------------

  // Empty slots finish at once with the unmapped pattern
  always_comb
  begin
    sel_ack   = 1'b1;
    sel_rdata = cfg_pkg::UNMAPPED_DATA;
    for (int i = 0; i < cfg_pkg::NUM_TST; i++)
    begin
      if (slot_sel == i)
      begin
        sel_ack   = cfg_rsp[i].ack;
        sel_rdata = cfg_rsp[i].rdata;
      end
    end
  end

  assign cyc_done = req_valid && sel_ack;

  // One request per access
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      did_req <= 1'b0;
    else if (state == ST_IDLE)
      did_req <= 1'b0;
    else if (req_fire)
      did_req <= 1'b1;
  end

  // Per-slot copies of the request, flopped for timing
  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      for (int i = 0; i < cfg_pkg::NUM_TST; i++)
      begin
        slot_addr[i]  <= req_addr;
        slot_wdata[i] <= w.data;
        slot_wstrb[i] <= w.strb;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      slot_wr <= '0;
      slot_rd <= '0;
    end
    else
    begin
      for (int i = 0; i < cfg_pkg::NUM_TST; i++)
      begin
        slot_wr[i] <= req_fire && cyc_wr && (slot_sel == i);
        slot_rd[i] <= req_fire && !cyc_wr && (slot_sel == i);
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < cfg_pkg::NUM_TST; i++)
    begin
      cfg_req[i].addr  = slot_addr[i];
      cfg_req[i].wdata = slot_wdata[i];
      cfg_req[i].wstrb = slot_wstrb[i];
      cfg_req[i].wr    = slot_wr[i];
      cfg_req[i].rd    = slot_rd[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == ST_CYC) && cyc_done)
      rdata_q <= sel_rdata;
  end

  // ------------------------------------------------------------
  // AXI handshakes
  // ------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      ar_ready <= 1'b0;
    end
    else
    begin
      aw_ready <= (state_nxt == ST_WR_ADDR);
      w_ready  <= (state == ST_CYC) && (state_nxt != ST_CYC) && cyc_wr;
      ar_ready <= (state == ST_CYC) && (state_nxt != ST_CYC) && !cyc_wr;
    end
  end

  assign b_valid = (state == ST_RESP) && cyc_wr;
  assign b.resp  = axil_pkg::RESP_OKAY;
  assign r_valid = (state == ST_RESP) && !cyc_wr;
  assign r.data  = rdata_q;
  assign r.resp  = axil_pkg::RESP_OKAY;

  a_wr_rd_excl: assert property (@(posedge clk) disable iff (!sync_rst_n)
    !((|slot_wr) && (|slot_rd)));

  a_slot_onehot: assert property (@(posedge clk) disable iff (!sync_rst_n)
    $onehot0(slot_wr) && $onehot0(slot_rd));

  a_rsp_excl: assert property (@(posedge clk) disable iff (!sync_rst_n)
    !(b_valid && r_valid));

endmodule

// ==== src/tst_cfg_regs.sv ====
module tst_cfg_regs #(
  parameter logic [31:0] BLOCK_ID  = 32'h0,
  parameter int          ACK_DELAY = 1
) (
  input  logic              clk,
  input  logic              sync_rst_n,
  input  cfg_pkg::cfg_req_t req,
  output cfg_pkg::cfg_rsp_t rsp
);

  logic [5:0]  offset;
  logic [31:0] scratch [4];
  logic [31:0] rd_val;
  logic [31:0] rdata_q;
  logic [7:0]  ack_cnt;

  // Word offset within the 256B slot
  assign offset = req.addr[7:2];

  // Offset 0 is the id, 1 to 4 scratch, rest read as zero
  always_comb
  begin
    rd_val = '0;
    if (offset == 6'd0)
      rd_val = BLOCK_ID;
    for (int i = 0; i < 4; i++)
    begin
      if (offset == 6'(i + 1))
        rd_val = scratch[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      scratch <= '{default: '0};
    else if (req.wr)
    begin
      for (int i = 0; i < 4; i++)
        for (int j = 0; j < 4; j++)
          if ((offset == 6'(i + 1)) && req.wstrb[j])
            scratch[i][8*j +: 8] <= req.wdata[8*j +: 8];
    end
  end

  always_ff @(posedge clk)
  begin
    if (req.rd || req.wr)
      rdata_q <= rd_val;
  end

  // Ack countdown, fires when the count reaches one
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      ack_cnt <= '0;
    else if (req.rd || req.wr)
      ack_cnt <= ACK_DELAY[7:0];
    else if (ack_cnt != '0)
      ack_cnt <= ack_cnt - 8'd1;
  end

  assign rsp.ack   = (ack_cnt == 8'd1);
  assign rsp.rdata = rdata_q;

  a_no_overlap: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (req.wr || req.rd) |-> (ack_cnt == '0));

endmodule

// ==== src/cl_ocl_top.sv ====
module cl_ocl_top (
  input  logic               clk,
  input  logic               sync_rst_n,
  input  axil_pkg::axil_aw_t s_aw,
  input  logic               s_aw_valid,
  output logic               s_aw_ready,
  input  axil_pkg::axil_w_t  s_w,
  input  logic               s_w_valid,
  output logic               s_w_ready,
  output axil_pkg::axil_b_t  s_b,
  output logic               s_b_valid,
  input  logic               s_b_ready,
  input  axil_pkg::axil_ar_t s_ar,
  input  logic               s_ar_valid,
  output logic               s_ar_ready,
  output axil_pkg::axil_r_t  s_r,
  output logic               s_r_valid,
  input  logic               s_r_ready
);

  // Slave side of the register slice
  axil_pkg::axil_aw_t m_aw;
  logic               m_aw_valid;
  logic               m_aw_ready;
  axil_pkg::axil_w_t  m_w;
  logic               m_w_valid;
  logic               m_w_ready;
  axil_pkg::axil_b_t  m_b;
  logic               m_b_valid;
  logic               m_b_ready;
  axil_pkg::axil_ar_t m_ar;
  logic               m_ar_valid;
  logic               m_ar_ready;
  axil_pkg::axil_r_t  m_r;
  logic               m_r_valid;
  logic               m_r_ready;

  cfg_pkg::cfg_req_t  cfg_req [cfg_pkg::NUM_TST];
  cfg_pkg::cfg_rsp_t  cfg_rsp [cfg_pkg::NUM_TST];

  axil_reg_slice u_slice (.*);

  ocl_slv u_slv (
    .clk, .sync_rst_n,
    .aw(m_aw), .aw_valid(m_aw_valid), .aw_ready(m_aw_ready),
    .w(m_w), .w_valid(m_w_valid), .w_ready(m_w_ready),
    .ar(m_ar), .ar_valid(m_ar_valid), .ar_ready(m_ar_ready),
    .b(m_b), .b_valid(m_b_valid), .b_ready(m_b_ready),
    .r(m_r), .r_valid(m_r_valid), .r_ready(m_r_ready),
    .cfg_req, .cfg_rsp
  );

  tst_cfg_regs #(.BLOCK_ID(32'h7e57_0000), .ACK_DELAY(1)) u_tst0 (
    .clk, .sync_rst_n, .req(cfg_req[0]), .rsp(cfg_rsp[0])
  );

  tst_cfg_regs #(.BLOCK_ID(32'h7e57_0001), .ACK_DELAY(3)) u_tst1 (
    .clk, .sync_rst_n, .req(cfg_req[1]), .rsp(cfg_rsp[1])
  );

  tst_cfg_regs #(.BLOCK_ID(32'h7e57_0002), .ACK_DELAY(6)) u_tst2 (
    .clk, .sync_rst_n, .req(cfg_req[2]), .rsp(cfg_rsp[2])
  );

  // Slot 3 is empty and answers at once like any unmapped slot
  assign cfg_rsp[3] = '{ack: 1'b1, rdata: cfg_pkg::UNMAPPED_DATA};

endmodule

// ==== test/tb_clk_gen.sv ====
module tb_clk_gen (
  output logic clk,
  output logic sync_rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 10;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Released on a falling edge after ten rising edges
  initial
  begin
    sync_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    sync_rst_n = 1'b1;
  end

endmodule

// ==== test/tb_cl_ocl.sv ====
module tb_cl_ocl;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_BLOCKS        = 3;
  localparam int NUM_SCRATCH       = 4;
  // Accesses per test, in run order
  localparam int NUM_ACCESSES      = 24 + 27 + 9 + 21 + 16;
  localparam int CYCLES_PER_ACCESS = 200;

  logic               clk;
  logic               sync_rst_n;
  axil_pkg::axil_aw_t s_aw;
  logic               s_aw_valid;
  logic               s_aw_ready;
  axil_pkg::axil_w_t  s_w;
  logic               s_w_valid;
  logic               s_w_ready;
  axil_pkg::axil_b_t  s_b;
  logic               s_b_valid;
  logic               s_b_ready;
  axil_pkg::axil_ar_t s_ar;
  logic               s_ar_valid;
  logic               s_ar_ready;
  axil_pkg::axil_r_t  s_r;
  logic               s_r_valid;
  logic               s_r_ready;

  int seed          = 32'h5838d28c;
  int value_errs    = 0;
  int protocol_errs = 0;
  int writes_issued = 0;
  int reads_issued  = 0;
  int b_seen        = 0;
  int r_seen        = 0;

  // Expected scratch contents per block
  logic [31:0] scratch_model [NUM_BLOCKS][NUM_SCRATCH];

  tb_clk_gen u_clk_gen (.clk, .sync_rst_n);

  cl_ocl_top i_dut (.*);

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  function automatic logic [31:0] reg_addr(input int slot, input int off);
    return {16'h0, slot[7:0], off[5:0], 2'b00};
  endfunction

  function automatic logic [31:0] predict_read(input logic [31:0] addr);
    int slot;
    int off;
    slot = int'(addr[15:8]);
    off  = int'(addr[7:2]);
    if (slot >= NUM_BLOCKS)
      return 32'hdead_beef;
    if (off == 0)
      return 32'h7e57_0000 + 32'(slot);
    if (off <= NUM_SCRATCH)
      return scratch_model[slot][off-1];
    return 32'h0;
  endfunction

  function automatic void apply_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
    int slot;
    int off;
    slot = int'(addr[15:8]);
    off  = int'(addr[7:2]);
    // Identity and unmapped offsets ignore writes
    if ((slot < NUM_BLOCKS) && (off >= 1) && (off <= NUM_SCRATCH))
    begin
      for (int j = 0; j < 4; j++)
        if (strb[j])
          scratch_model[slot][off-1][8*j +: 8] = data[8*j +: 8];
    end
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // ------------------------------------------------------------
  // Bus tasks
  // ------------------------------------------------------------

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      value_errs++;
      $display("ERR %0t %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic send_requests(input bit do_wr, input bit do_rd, input logic [31:0] addr,
                               input logic [31:0] data, input logic [3:0] strb);
    bit aw_fire;
    bit w_fire;
    bit ar_fire;
    @(negedge clk);
    if (do_wr)
    begin
      s_aw.addr  = addr;
      s_aw_valid = 1'b1;
      s_w.data   = data;
      s_w.strb   = strb;
      s_w_valid  = 1'b1;
      writes_issued++;
    end
    if (do_rd)
    begin
      s_ar.addr  = addr;
      s_ar_valid = 1'b1;
      reads_issued++;
    end
    // Ready comes from flops, so it is settled at the falling edge
    while (s_aw_valid || s_w_valid || s_ar_valid)
    begin
      aw_fire = s_aw_valid && s_aw_ready;
      w_fire  = s_w_valid && s_w_ready;
      ar_fire = s_ar_valid && s_ar_ready;
      @(negedge clk);
      if (aw_fire)
        s_aw_valid = 1'b0;
      if (w_fire)
        s_w_valid = 1'b0;
      if (ar_fire)
        s_ar_valid = 1'b0;
    end
  endtask

  task automatic collect_b(input int stall);
    axil_pkg::axil_b_t held;
    while (!s_b_valid)
      @(negedge clk);
    held = s_b;
    repeat (stall)
    begin
      @(negedge clk);
      assert (s_b_valid)
      else
      begin
        protocol_errs++;
        $display("Write response dropped before it was accepted at %0t", $time);
      end
      check_word("s_b.resp", 32'(s_b.resp), 32'(held.resp));
    end
    s_b_ready = 1'b1;
    @(negedge clk);
    s_b_ready = 1'b0;
    check_word("s_b.resp", 32'(held.resp), 32'(axil_pkg::RESP_OKAY));
    assert (!s_b_valid)
    else
    begin
      protocol_errs++;
      $display("Second write response showed up at %0t", $time);
    end
  endtask

  task automatic collect_r(input int stall, output logic [31:0] data);
    axil_pkg::axil_r_t held;
    while (!s_r_valid)
      @(negedge clk);
    held = s_r;
    repeat (stall)
    begin
      @(negedge clk);
      assert (s_r_valid)
      else
      begin
        protocol_errs++;
        $display("Read response dropped before it was accepted at %0t", $time);
      end
      check_word("s_r.data", s_r.data, held.data);
    end
    s_r_ready = 1'b1;
    @(negedge clk);
    s_r_ready = 1'b0;
    check_word("s_r.resp", 32'(held.resp), 32'(axil_pkg::RESP_OKAY));
    assert (!s_r_valid)
    else
    begin
      protocol_errs++;
      $display("Second read response showed up at %0t", $time);
    end
    data = held.data;
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    send_requests(1'b1, 1'b0, addr, data, strb);
    collect_b(0);
    apply_write(addr, data, strb);
  endtask

  task automatic axil_read(input logic [31:0] addr);
    logic [31:0] got;
    send_requests(1'b0, 1'b1, addr, '0, '0);
    collect_r(0, got);
    check_word($sformatf("s_r.data at %h", addr), got, predict_read(addr));
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic test_scratch_rw();
    for (int b = 0; b < NUM_BLOCKS; b++)
      for (int k = 1; k <= NUM_SCRATCH; k++)
        axil_write(reg_addr(b, k), rand_word(), 4'hf);
    for (int b = 0; b < NUM_BLOCKS; b++)
      for (int k = 1; k <= NUM_SCRATCH; k++)
        axil_read(reg_addr(b, k));
  endtask

  task automatic test_byte_strobes();
    logic [3:0] strbs [4];
    strbs = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    for (int b = 0; b < NUM_BLOCKS; b++)
    begin
      axil_write(reg_addr(b, 2), rand_word(), 4'hf);
      for (int k = 0; k < 4; k++)
      begin
        axil_write(reg_addr(b, 2), rand_word(), strbs[k]);
        axil_read(reg_addr(b, 2));
      end
    end
  endtask

  task automatic test_identity();
    for (int b = 0; b < NUM_BLOCKS; b++)
    begin
      axil_read(reg_addr(b, 0));
      axil_write(reg_addr(b, 0), rand_word(), 4'hf);
      axil_read(reg_addr(b, 0));
    end
  endtask

  task automatic test_unmapped();
    int slots [3];
    slots = '{3, 5, 200};
    for (int s = 0; s < 3; s++)
    begin
      axil_read(reg_addr(slots[s], 0));
      axil_read(reg_addr(slots[s], 1));
    end
    for (int s = 0; s < 3; s++)
      axil_write(reg_addr(slots[s], s + 1), rand_word(), 4'hf);
    // No block may have picked up those writes
    for (int b = 0; b < NUM_BLOCKS; b++)
      for (int k = 1; k <= NUM_SCRATCH; k++)
        axil_read(reg_addr(b, k));
  endtask

  // Write and read of one register offered together, then stalled responses
  task automatic test_priority_backpressure();
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] got;
    for (int i = 0; i < 8; i++)
    begin
      addr = reg_addr(rand_below(NUM_BLOCKS), 1 + rand_below(NUM_SCRATCH));
      data = rand_word();
      send_requests(1'b1, 1'b1, addr, data, 4'hf);
      collect_b(rand_below(12));
      apply_write(addr, data, 4'hf);
      collect_r(rand_below(12), got);
      check_word($sformatf("s_r.data at %h", addr), got, predict_read(addr));
    end
  endtask

  // ------------------------------------------------------------
  // Run control
  // ------------------------------------------------------------

  always @(posedge clk)
  begin
    if (sync_rst_n)
    begin
      if (s_b_valid && s_b_ready)
        b_seen++;
      if (s_r_valid && s_r_ready)
        r_seen++;
    end
  end

  initial
  begin
    repeat (NUM_ACCESSES * CYCLES_PER_ACCESS + 20) @(posedge clk);
    $display("Timeout after %0d cycles, the tests did not finish",
             NUM_ACCESSES * CYCLES_PER_ACCESS + 20);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    s_aw       = '0;
    s_aw_valid = 1'b0;
    s_w        = '0;
    s_w_valid  = 1'b0;
    s_b_ready  = 1'b0;
    s_ar       = '0;
    s_ar_valid = 1'b0;
    s_r_ready  = 1'b0;
    for (int b = 0; b < NUM_BLOCKS; b++)
      for (int k = 0; k < NUM_SCRATCH; k++)
        scratch_model[b][k] = 32'h0;
    wait (sync_rst_n === 1'b1);
    repeat (2) @(negedge clk);

    test_scratch_rw();
    test_byte_strobes();
    test_identity();
    test_unmapped();
    test_priority_backpressure();

    repeat (4) @(negedge clk);
    assert ((b_seen == writes_issued) && (r_seen == reads_issued))
    else
    begin
      protocol_errs++;
      $display("Response count mismatch, b %0d of %0d, r %0d of %0d",
               b_seen, writes_issued, r_seen, reads_issued);
    end
    $display("Error counts: value %0d, protocol %0d", value_errs, protocol_errs);
    if ((value_errs == 0) && (protocol_errs == 0))
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== sources.f ====
src/axil_pkg.sv
src/cfg_pkg.sv
src/chan_flop_fifo.sv
src/axil_reg_slice.sv
src/ocl_slv.sv
src/tst_cfg_regs.sv
src/cl_ocl_top.sv
test/tb_clk_gen.sv
test/tb_cl_ocl.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_cl_ocl -f sources.f
	./obj_dir/Vtb_cl_ocl | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
